/* common/uart_pkg.sv */
// shared frame constants and FSM state types for the multi-channel UART
// imported by the channel, the collector and the top level

`default_nettype none

package uart_pkg;

  //--------------------------------------------------
  // frame format
  //--------------------------------------------------
  // 8N1 only, no parity
  localparam int data_bits  = 8;
  localparam int oversample = 16; // ticks per bit

  //--------------------------------------------------
  // receiver states
  //--------------------------------------------------
  typedef enum logic [1:0] {
    rx_idle,  // waiting for falling edge
    rx_start, // start bit seen, verify at mid-bit
    rx_shift, // data bits, lsb first
    rx_stop   // sample stop bit
  } rx_state_t;

  //--------------------------------------------------
  // transmitter states
  //--------------------------------------------------
  typedef enum logic [1:0] {
    tx_idle,  // line at mark
    tx_start, // driving start bit
    tx_shift, // driving data bits
    tx_stop   // driving stop bit, still busy
  } tx_state_t;

endpackage

`default_nettype wire

/* hw/baud_tick_gen.sv */
// 16x oversample enable shared by every UART channel
// tick is high for one clk in every divisor cycles

`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen import uart_pkg::*; #(
  parameter int freq_hz = 25_000_000,
  parameter int baud    = 115_200
) (
  input  logic clk,
  input  logic reset,
  output logic tick
);

  localparam int          divisor = freq_hz / baud / oversample;
  localparam logic [15:0] reload  = 16'(divisor - 1);

  logic [15:0] cnt; // down-counter

  assign tick = (cnt == 16'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= reload;
    end else if (tick) begin
      cnt <= reload; // wrap
    end else begin
      cnt <= cnt - 16'd1;
    end
  end

endmodule

`default_nettype wire

/* uart_chan/uart_chan.sv */
// one full-duplex 8N1 UART channel running on the shared 16x tick
// rx flags hold until rx_ack, tx writes while busy are dropped
// start bit is verified at mid-bit, data goes lsb first

`timescale 1ns/1ps
`default_nettype none

module uart_chan import uart_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 rxd,
  input  logic [data_bits-1:0] tx_data,
  input  logic                 tx_wr,
  output logic                 txd,
  output logic                 tx_busy,
  output logic [data_bits-1:0] rx_data,
  output logic                 rx_avail,
  output logic                 rx_error,
  input  logic                 rx_ack
);

  localparam int             bit_w    = $clog2(data_bits);
  localparam logic [bit_w-1:0] last_bit = bit_w'(data_bits - 1);

  //--------------------------------------------------
  // input synchronizer
  //--------------------------------------------------
  logic rxd_meta;
  logic rxd_s;

  always_ff @(posedge clk) begin
    if (reset) begin
      rxd_meta <= 1'b1; // line idles at mark
      rxd_s    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_s    <= rxd_meta;
    end
  end

  //--------------------------------------------------
  // receiver
  //--------------------------------------------------
  rx_state_t            rx_state;
  logic [3:0]           rx_tick_cnt;
  logic [bit_w-1:0]     rx_bit_cnt;
  logic [data_bits-1:0] rx_shreg;
  logic                 rx_hold;   // break seen, wait for mark
  logic                 rx_sample;

  // 8 ticks after detection, then every 16
  assign rx_sample = tick && (rx_tick_cnt == 4'd15);

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_state    <= rx_idle;
      rx_tick_cnt <= 4'd0;
      rx_bit_cnt  <= '0;
      rx_hold     <= 1'b0;
      rx_avail    <= 1'b0;
      rx_error    <= 1'b0;
    end else begin
      if (rx_ack) begin
        rx_avail <= 1'b0;
        rx_error <= 1'b0;
      end
      if (tick && rx_state != rx_idle) rx_tick_cnt <= rx_tick_cnt + 4'd1;

      case (rx_state)
        rx_idle: begin
          if (tick) begin
            if (rx_hold) begin
              if (rxd_s) rx_hold <= 1'b0; // line back at mark
            end else if (!rxd_s) begin
              rx_state    <= rx_start;
              rx_tick_cnt <= 4'd8; // half a bit to the middle
            end
          end
        end
        rx_start: begin
          if (rx_sample) begin
            if (rxd_s) begin
              rx_state <= rx_idle; // glitch, not a start bit
            end else begin
              rx_state   <= rx_shift;
              rx_bit_cnt <= '0;
            end
          end
        end
        rx_shift: begin
          if (rx_sample) begin
            rx_shreg   <= {rxd_s, rx_shreg[data_bits-1:1]};
            rx_bit_cnt <= rx_bit_cnt + 1'b1;
            if (rx_bit_cnt == last_bit) rx_state <= rx_stop;
          end
        end
        rx_stop: begin
          if (rx_sample) begin
            rx_state <= rx_idle;
            if (rxd_s) begin // good stop
              rx_avail <= 1'b1;
              rx_error <= 1'b0;
            end else begin   // framing error
              rx_error <= 1'b1;
              rx_hold  <= 1'b1;
            end
          end
        end
        default: rx_state <= rx_idle;
      endcase
    end
  end

  // received byte, updated only on a good stop bit
  always_ff @(posedge clk) begin
    if (rx_state == rx_stop && rx_sample && rxd_s) rx_data <= rx_shreg;
  end

  //--------------------------------------------------
  // transmitter
  //--------------------------------------------------
  tx_state_t            tx_state;
  logic [3:0]           tx_tick_cnt;
  logic [bit_w-1:0]     tx_bit_cnt;
  logic [data_bits-1:0] tx_shreg;
  logic                 tx_bound; // end of current bit
  logic                 tx_load;

  assign tx_bound = tick && (tx_tick_cnt == 4'd15);
  assign tx_load  = tx_wr && !tx_busy; // busy writes dropped

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_state    <= tx_idle;
      tx_tick_cnt <= 4'd0;
      tx_bit_cnt  <= '0;
      tx_busy     <= 1'b0;
      txd         <= 1'b1;
    end else begin
      if (tick && tx_state != tx_idle) tx_tick_cnt <= tx_tick_cnt + 4'd1;

      case (tx_state)
        tx_idle: begin
          if (tx_load) begin
            tx_state    <= tx_start;
            tx_busy     <= 1'b1;
            tx_tick_cnt <= 4'd0;
            txd         <= 1'b0; // start bit
          end
        end
        tx_start: begin
          if (tx_bound) begin
            tx_state   <= tx_shift;
            tx_bit_cnt <= '0;
            txd        <= tx_shreg[0];
          end
        end
        tx_shift: begin
          if (tx_bound) begin
            if (tx_bit_cnt == last_bit) begin
              tx_state <= tx_stop;
              txd      <= 1'b1;
            end else begin
              tx_bit_cnt <= tx_bit_cnt + 1'b1;
              txd        <= tx_shreg[1];
            end
          end
        end
        tx_stop: begin
          if (tx_bound) begin
            tx_state <= tx_idle;
            tx_busy  <= 1'b0; // stop bit done
          end
        end
        default: tx_state <= tx_idle;
      endcase
    end
  end

  // data shift register, loaded on accepted write
  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_shreg <= tx_data;
    end else if (tx_bound && tx_state == tx_shift) begin
      tx_shreg <= {1'b0, tx_shreg[data_bits-1:1]};
    end
  end

endmodule

`default_nettype wire

/* hw/rx_collector.sv */
// round-robin drain of all channels' rx flags into one tagged stream
// out_valid pulses one cycle per byte or error, with the channel index
// the acked channel is masked while its flags clear

`timescale 1ns/1ps
`default_nettype none

module rx_collector import uart_pkg::*; #(
  parameter int num_chan = 4
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [num_chan-1:0]                  rx_avail,
  input  logic [num_chan-1:0]                  rx_error,
  input  logic [num_chan-1:0][data_bits-1:0]   rx_data,
  output logic [num_chan-1:0]                  rx_ack,
  output logic [data_bits-1:0]                 out_data,
  output logic [((num_chan > 1) ? $clog2(num_chan) : 1)-1:0] out_chan,
  output logic                                 out_error,
  output logic                                 out_valid
);

  localparam int chan_w = (num_chan > 1) ? $clog2(num_chan) : 1;

  logic [num_chan-1:0] req;   // flagged and not just acked
  logic [chan_w-1:0]   last;  // last channel served
  logic [chan_w-1:0]   pick;
  logic                found;

  // rx_ack doubles as the one-cycle mask
  assign req = (rx_avail | rx_error) & ~rx_ack;

  //--------------------------------------------------
  // round-robin search, starting after last
  //--------------------------------------------------
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = '0;
    for (int k = 1; k <= num_chan; k++) begin
      idx = int'(last) + k;
      if (idx >= num_chan) idx = idx - num_chan; // wrap
      if (!found && req[idx]) begin
        found = 1'b1;
        pick  = chan_w'(idx);
      end
    end
  end

  //--------------------------------------------------
  // control: valid strobe, ack, pointer
  //--------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      rx_ack    <= '0;
      last      <= chan_w'(num_chan - 1); // first search starts at 0
    end else begin
      out_valid <= found;
      rx_ack    <= '0;
      if (found) begin
        rx_ack[pick] <= 1'b1;
        last         <= pick;
      end
    end
  end

  // output fields, qualified by out_valid
  always_ff @(posedge clk) begin
    if (found) begin
      out_data  <= rx_data[pick];
      out_chan  <= pick;
      out_error <= rx_error[pick];
    end
  end

endmodule

`default_nettype wire

/* hw/multi_uart.sv */
// multi-channel UART top: shared baud tick, num_chan channels, rx collector
// tx writes go to the channel picked by tx_chan, rx comes out tagged

`timescale 1ns/1ps
`default_nettype none

module multi_uart import uart_pkg::*; #(
  parameter int freq_hz  = 25_000_000,
  parameter int baud     = 115_200,
  parameter int num_chan = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [num_chan-1:0]  rxd,
  input  logic [data_bits-1:0] tx_data,
  input  logic [((num_chan > 1) ? $clog2(num_chan) : 1)-1:0] tx_chan,
  input  logic                 tx_wr,
  output logic [num_chan-1:0]  txd,
  output logic [num_chan-1:0]  tx_busy,
  output logic [data_bits-1:0] out_data,
  output logic [((num_chan > 1) ? $clog2(num_chan) : 1)-1:0] out_chan,
  output logic                 out_error,
  output logic                 out_valid
);

  localparam int chan_w = (num_chan > 1) ? $clog2(num_chan) : 1;

  logic                               tick;
  logic [num_chan-1:0]                chan_wr;  // decoded write strobes
  logic [num_chan-1:0][data_bits-1:0] rx_data;
  logic [num_chan-1:0]                rx_avail;
  logic [num_chan-1:0]                rx_error;
  logic [num_chan-1:0]                rx_ack;   // one-hot from collector

  baud_tick_gen #(
    .freq_hz (freq_hz),
    .baud    (baud)
  ) baud_tick_gen_inst (
    .clk   (clk),
    .reset (reset),
    .tick  (tick)
  );

  //--------------------------------------------------
  // channels
  //--------------------------------------------------
  for (genvar i = 0; i < num_chan; i++) begin : g_chan
    assign chan_wr[i] = tx_wr && (tx_chan == chan_w'(i));

    uart_chan uart_chan_inst (
      .clk      (clk),
      .reset    (reset),
      .tick     (tick),
      .rxd      (rxd[i]),
      .tx_data  (tx_data),
      .tx_wr    (chan_wr[i]),
      .txd      (txd[i]),
      .tx_busy  (tx_busy[i]),
      .rx_data  (rx_data[i]),
      .rx_avail (rx_avail[i]),
      .rx_error (rx_error[i]),
      .rx_ack   (rx_ack[i])
    );
  end

  rx_collector #(
    .num_chan (num_chan)
  ) rx_collector_inst (
    .clk       (clk),
    .reset     (reset),
    .rx_avail  (rx_avail),
    .rx_error  (rx_error),
    .rx_data   (rx_data),
    .rx_ack    (rx_ack),
    .out_data  (out_data),
    .out_chan  (out_chan),
    .out_error (out_error),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

/* verif/multi_uart_chk.sv */
// concurrent checks on the multi_uart ports
// bound into every multi_uart instance
// covers output pulse spacing, idle tx lines and quiet outputs around reset

`timescale 1ns/1ps
`default_nettype none

module multi_uart_chk #(
  parameter int num_chan = 4
) (
  input logic                clk,
  input logic                reset,
  input logic [num_chan-1:0] txd,
  input logic [num_chan-1:0] tx_busy,
  input logic [((num_chan > 1) ? $clog2(num_chan) : 1)-1:0] out_chan,
  input logic                out_valid
);

  int fail_count = 0; // failed assertion count

  // acked channel is masked for one cycle
  valid_no_repeat: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |=> !(out_valid && out_chan == $past(out_chan))
  ) else begin
    $error("out_valid high two cycles in a row on channel %0d", out_chan);
    fail_count++;
  end

  for (genvar i = 0; i < num_chan; i++) begin : g_line
    idle_line_high: assert property (
      @(posedge clk) disable iff (reset)
      !tx_busy[i] |-> txd[i] // mark when idle
    ) else begin
      $error("txd low on channel %0d with tx_busy low", i);
      fail_count++;
    end
  end

  reset_quiet: assert property (
    @(posedge clk) reset |=> (!out_valid && tx_busy == '0)
  ) else begin
    $error("out_valid or tx_busy high during reset");
    fail_count++;
  end

  // first cycle out of reset
  release_quiet: assert property (
    @(posedge clk) $fell(reset) |=> (!out_valid && tx_busy == '0)
  ) else begin
    $error("out_valid or tx_busy high on the first cycle after reset");
    fail_count++;
  end

endmodule

bind multi_uart multi_uart_chk #(
  .num_chan (num_chan)
) multi_uart_chk_inst (
  .clk       (clk),
  .reset     (reset),
  .txd       (txd),
  .tx_busy   (tx_busy),
  .out_chan  (out_chan),
  .out_valid (out_valid)
);

`default_nettype wire

/* verif/multi_uart_tb.sv */
// testbench for multi_uart with each txd looped back to its rxd
// random bytes go out per channel and the tagged receive stream is
// checked against a per-channel scoreboard, one result line per test

`timescale 1ns/1ps
`default_nettype none

module multi_uart_tb;

  localparam int num_chan   = 4;
  localparam int chan_w     = 2;
  localparam int bit_cycles = 16;   // divisor of 1 gives a tick every clk
  localparam int max_cycles = 2500; // 12 frames of 160 plus margin

  logic                clk;
  logic                reset;
  logic [num_chan-1:0] rxd;
  logic [7:0]          tx_data;
  logic [chan_w-1:0]   tx_chan;
  logic                tx_wr;
  logic [num_chan-1:0] txd;
  logic [num_chan-1:0] tx_busy;
  logic [7:0]          out_data;
  logic [chan_w-1:0]   out_chan;
  logic                out_error;
  logic                out_valid;
  logic [num_chan-1:0] rxd_low;              // forces a line to space

  logic [7:0]          exp_data [num_chan]; // scoreboard with one entry per channel
  logic [num_chan-1:0] exp_pend;
  logic [num_chan-1:0] exp_err;
  integer              seed;
  int                  cycles       = 0;
  int                  errors       = 0;
  int                  test_errors  = 0;    // error count at test start
  int                  chk_seen     = 0;    // checker failures already counted
  int                  tests_run    = 0;
  int                  tests_failed = 0;

  assign rxd = txd & ~rxd_low; // loopback unless held low

  multi_uart #(
    .freq_hz  (1_600_000),
    .baud     (100_000),
    .num_chan (num_chan)
  ) multi_uart_inst (
    .clk       (clk),
    .reset     (reset),
    .rxd       (rxd),
    .tx_data   (tx_data),
    .tx_chan   (tx_chan),
    .tx_wr     (tx_wr),
    .txd       (txd),
    .tx_busy   (tx_busy),
    .out_data  (out_data),
    .out_chan  (out_chan),
    .out_error (out_error),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //--------------------------------------------------
  // run limit
  //--------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // one-cycle write strobe driven on the rising edge
  task automatic write_byte(input logic [chan_w-1:0] ch, input logic [7:0] d);
    @(posedge clk);
    tx_chan <= ch;
    tx_data <= d;
    tx_wr   <= 1'b1;
    @(posedge clk);
    tx_wr   <= 1'b0;
  endtask

  task automatic expect_rx(input logic [chan_w-1:0] ch, input logic [7:0] d,
                           input logic err);
    exp_data[ch] = d;
    exp_err[ch]  = err;
    exp_pend[ch] = 1'b1;
  endtask

  // wait for n output pulses and check each against the scoreboard
  task automatic collect(input string name, input int n);
    logic [chan_w-1:0] ch;
    for (int k = 0; k < n; k++) begin
      @(negedge clk);
      while (!out_valid) @(negedge clk);
      ch = out_chan;
      assert (exp_pend[ch]) else begin
        $display("%s: output on channel %0d with nothing expected", name, ch);
        errors++;
      end
      assert (out_error == exp_err[ch]) else begin
        $display("Mismatch %s: channel %0d out_error expected %0b actual %0b",
                 name, ch, exp_err[ch], out_error);
        errors++;
      end
      if (!exp_err[ch]) begin // data only meaningful on a good frame
        assert (out_data == exp_data[ch]) else begin
          $display("Mismatch %s: channel %0d out_data expected %02h actual %02h",
                   name, ch, exp_data[ch], out_data);
          errors++;
        end
      end
      exp_pend[ch] = 1'b0;
    end
  endtask

  // no stray pulse for n cycles and nothing left outstanding
  task automatic expect_quiet(input string name, input int n);
    repeat (n) begin
      @(negedge clk);
      assert (!out_valid) else begin
        $display("%s: extra out_valid on channel %0d", name, out_chan);
        errors++;
      end
    end
    assert (exp_pend == '0) else begin
      $display("%s: expected output never arrived, pending %b", name, exp_pend);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    int chk_now;
    chk_now  = multi_uart_inst.multi_uart_chk_inst.fail_count;
    errors  += chk_now - chk_seen; // bound assertion failures in this test
    chk_seen = chk_now;
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_errors);
      tests_failed++;
    end
    test_errors = errors;
  endtask

  //--------------------------------------------------
  // stimulus
  //--------------------------------------------------
  initial begin
    logic [7:0] b;
    logic       dup;
    int         start;
    seed     = 97;
    exp_pend = '0;
    exp_err  = '0;
    reset   <= 1'b1;
    tx_data <= '0;
    tx_chan <= '0;
    tx_wr   <= 1'b0;
    rxd_low <= '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // idle lines after reset
    @(negedge clk);
    assert (txd == '1) else begin
      $display("Mismatch reset_state: txd expected 1111 actual %b", txd);
      errors++;
    end
    assert (tx_busy == '0) else begin
      $display("Mismatch reset_state: tx_busy expected 0000 actual %b", tx_busy);
      errors++;
    end
    expect_quiet("reset_state", 4 * bit_cycles);
    end_test("reset_state");

    // one channel at a time
    for (int ch = 0; ch < num_chan; ch++) begin
      b = 8'($random(seed));
      expect_rx(chan_w'(ch), b, 1'b0);
      write_byte(chan_w'(ch), b);
      collect("single_loopback", 1);
    end
    expect_quiet("single_loopback", 2 * bit_cycles);
    end_test("single_loopback");

    // distinct bytes to all channels in back to back writes
    while (tx_busy != '0) @(negedge clk);
    for (int ch = 0; ch < num_chan; ch++) begin
      do begin
        b   = 8'($random(seed));
        dup = 1'b0;
        for (int j = 0; j < ch; j++) begin
          if (exp_data[j] == b) dup = 1'b1;
        end
      end while (dup);
      expect_rx(chan_w'(ch), b, 1'b0);
    end
    for (int ch = 0; ch < num_chan; ch++) begin
      @(posedge clk);
      tx_chan <= chan_w'(ch);
      tx_data <= exp_data[ch];
      tx_wr   <= 1'b1;
    end
    @(posedge clk);
    tx_wr <= 1'b0;
    collect("all_channels", num_chan);
    expect_quiet("all_channels", 2 * bit_cycles);
    end_test("all_channels");

    // a write while busy is dropped
    while (tx_busy != '0) @(negedge clk);
    b = 8'($random(seed));
    expect_rx(1, b, 1'b0);
    write_byte(1, b);
    @(negedge clk);
    assert (tx_busy[1]) else begin
      $display("busy_drop: tx_busy did not rise after the first write");
      errors++;
    end
    write_byte(1, ~b); // mid-frame write that must not show up
    collect("busy_drop", 1);
    while (tx_busy[1]) @(negedge clk);
    b = 8'($random(seed));
    expect_rx(1, b, 1'b0);
    write_byte(1, b);
    @(negedge clk);
    assert (tx_busy[1]) else begin
      $display("busy_drop: write after tx_busy fell was not accepted");
      errors++;
    end
    collect("busy_drop", 1);
    expect_quiet("busy_drop", 2 * bit_cycles);
    end_test("busy_drop");

    // break on channel 2 gives a framing error before normal traffic
    while (tx_busy != '0) @(negedge clk);
    expect_rx(2, 8'h00, 1'b1);
    @(posedge clk);
    rxd_low[2] <= 1'b1;
    start = cycles;
    collect("framing_error", 1);
    while (cycles - start < 12 * bit_cycles) @(posedge clk);
    rxd_low[2] <= 1'b0;
    repeat (bit_cycles) @(posedge clk); // line back at mark
    b = 8'($random(seed));
    expect_rx(2, b, 1'b0);
    write_byte(2, b);
    collect("framing_error", 1);
    expect_quiet("framing_error", 2 * bit_cycles);
    end_test("framing_error");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* multi_uart.f */
common/uart_pkg.sv
hw/baud_tick_gen.sv
uart_chan/uart_chan.sv
hw/rx_collector.sv
hw/multi_uart.sv
verif/multi_uart_chk.sv
verif/multi_uart_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the multi_uart testbench with Verilator, runs it, checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module multi_uart_tb \
  -f multi_uart.f \
  --Mdir obj_dir -o sim_multi_uart
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_multi_uart > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1
